/* dmr_pkg.sv */
package dmr_pkg;

  // Width of a register value and of a host bus word
  localparam int unsigned DataWidth = 32;

  // Width of a core register index, up to 32 shadow entries
  localparam int unsigned RegAddrWidth = 5;

  // Bit positions inside REG_CTRL
  localparam int unsigned CtrlEnableBit = 0;
  localparam int unsigned CtrlRapidBit  = 1;
  localparam int unsigned CtrlForceBit  = 2;

  // Lockstep mode of the core pair
  typedef enum logic [1:0] {
    NON_DMR     = 2'd0,
    DMR_RUN     = 2'd1,
    DMR_RESTORE = 2'd2
  } dmr_mode_e;

  // State of the checkpoint replay engine
  typedef enum logic [1:0] {
    REC_IDLE   = 2'd0,
    REC_REPLAY = 2'd1,
    REC_DONE   = 2'd2
  } rec_state_e;

  // Register map of the host bus
  // REG_CTRL holds enable, rapid recovery and force recovery
  // REG_STATUS is read only, mode in bits 1:0
  // REG_MISMATCH is a read only count, any write clears it
  typedef enum logic [1:0] {
    REG_CTRL     = 2'd0,
    REG_STATUS   = 2'd1,
    REG_MISMATCH = 2'd2
  } reg_addr_e;

endpackage

/* dmr_cfg_if.sv */
interface dmr_cfg_if;
  import dmr_pkg::*;

  // Control bits from the register block
  logic dmr_enable;
  logic rapid_recovery;
  logic force_recovery;

  // Current lockstep mode, shown in REG_STATUS
  dmr_mode_e mode;

  // Single cycle pulse once a forced recovery is taken
  logic force_clear;

  // Single cycle pulse per detected mismatch
  logic mismatch_incr;

  // Register block side
  modport regs (
    output dmr_enable, rapid_recovery, force_recovery,
    input  mode, force_clear, mismatch_incr
  );

  // Lockstep FSM side
  modport ctrl (
    input  dmr_enable, rapid_recovery, force_recovery,
    output mode, force_clear, mismatch_incr
  );

endinterface

/* dmr_regs.sv */
module dmr_regs #(
  parameter bit RapidRecovery = 1'b1
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // Four-phase host bus
  input  logic                          reg_req_i,
  input  logic                          reg_we_i,
  input  dmr_pkg::reg_addr_e            reg_addr_i,
  input  logic [dmr_pkg::DataWidth-1:0] reg_wdata_i,
  output logic                          reg_ack_o,
  output logic [dmr_pkg::DataWidth-1:0] reg_rdata_o,
  // Configuration and status towards the FSM
  dmr_cfg_if.regs                       cfg
);
  import dmr_pkg::*;

  // Handshake states of the bus slave
  typedef enum logic {
    ACK_IDLE = 1'b0,
    ACK_HOLD = 1'b1
  } ack_state_e;

  ack_state_e           ack_q;
  logic                 access;
  logic                 wr_ctrl;
  logic                 wr_mismatch;
  logic                 dmr_enable_q;
  logic                 rapid_q;
  logic                 force_q;
  logic [DataWidth-1:0] mismatch_cnt_q;
  logic [DataWidth-1:0] rdata_d;
  logic [DataWidth-1:0] rdata_q;

  // A request is served on the edge where ack rises
  assign access      = (ack_q == ACK_IDLE) && reg_req_i;
  assign wr_ctrl     = access && reg_we_i && (reg_addr_i == REG_CTRL);
  assign wr_mismatch = access && reg_we_i && (reg_addr_i == REG_MISMATCH);

  // Ack rises after req is seen, falls after req drops
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= ACK_IDLE;
    end else if (ack_q == ACK_IDLE) begin
      if (reg_req_i) begin
        ack_q <= ACK_HOLD;
      end
    end else if (!reg_req_i) begin
      ack_q <= ACK_IDLE;
    end
  end

  assign reg_ack_o = (ack_q == ACK_HOLD);

  // Read mux
  always_comb begin
    rdata_d = '0;
    case (reg_addr_i)
      REG_CTRL: begin
        rdata_d[CtrlEnableBit] = dmr_enable_q;
        rdata_d[CtrlRapidBit]  = rapid_q;
        rdata_d[CtrlForceBit]  = force_q;
      end
      REG_STATUS:   rdata_d[1:0] = cfg.mode;
      REG_MISMATCH: rdata_d      = mismatch_cnt_q;
      default:      rdata_d      = '0;
    endcase
  end

  // Read data held stable while ack is high
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (access) begin
      rdata_q <= rdata_d;
    end
  end

  assign reg_rdata_o = rdata_q;

  // Control bits, a host write wins over the FSM clear
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dmr_enable_q <= 1'b0;
      rapid_q      <= 1'b0;
      force_q      <= 1'b0;
    end else begin
      if (cfg.force_clear) begin
        force_q <= 1'b0;
      end
      if (wr_ctrl) begin
        dmr_enable_q <= reg_wdata_i[CtrlEnableBit];
        // Tied low when the hardware has no rapid recovery
        rapid_q      <= reg_wdata_i[CtrlRapidBit] & RapidRecovery;
        force_q      <= reg_wdata_i[CtrlForceBit];
      end
    end
  end

  // Saturating mismatch counter
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mismatch_cnt_q <= '0;
    end else if (wr_mismatch) begin
      mismatch_cnt_q <= '0;
    end else if (cfg.mismatch_incr && (mismatch_cnt_q != '1)) begin
      mismatch_cnt_q <= mismatch_cnt_q + DataWidth'(1);
    end
  end

  assign cfg.dmr_enable     = dmr_enable_q;
  assign cfg.rapid_recovery = rapid_q;
  assign cfg.force_recovery = force_q;

endmodule

/* dmr_ctrl.sv */
module dmr_ctrl #(
  parameter bit RapidRecovery = 1'b1
) (
  input  logic    clk_i,
  input  logic    rst_ni,
  // Configuration and status from the register block
  dmr_cfg_if.ctrl cfg,
  // Core pair state
  input  logic    fetch_en_i,
  input  logic    cores_synch_i,
  // Comparator result
  input  logic    error_i,
  output logic    compare_en_o,
  // Checkpoint handshake
  output logic    recovery_req_o,
  input  logic    recovery_done_i,
  // Towards the cores and software
  output logic    setback_o,
  output logic    sw_resynch_req_o,
  output logic    grp_in_independent_o
);
  import dmr_pkg::*;

  dmr_mode_e mode_d;
  dmr_mode_e mode_q;
  logic      rapid_en;

  // Rapid recovery needs both the hardware option and the register bit
  assign rapid_en = cfg.rapid_recovery && RapidRecovery;

  always_comb begin
    mode_d            = mode_q;
    sw_resynch_req_o  = 1'b0;
    cfg.force_clear   = 1'b0;
    cfg.mismatch_incr = 1'b0;

    case (mode_q)
      DMR_RUN: begin
        // Software asked for a recovery without a mismatch
        if (cfg.force_recovery && rapid_en) begin
          mode_d          = DMR_RESTORE;
          cfg.force_clear = 1'b1;
        end
        // Mismatch, counted on either path
        if (error_i) begin
          cfg.mismatch_incr = 1'b1;
          if (rapid_en) begin
            mode_d = DMR_RESTORE;
          end else begin
            sw_resynch_req_o = 1'b1;
          end
        end
      end

      DMR_RESTORE: begin
        // Back to lockstep once the replay has ended
        if (recovery_done_i) begin
          mode_d = DMR_RUN;
        end
      end

      default: begin
        mode_d = mode_q;
      end
    endcase

    // Before the cores fetch, mode simply follows the enable bit
    if (!fetch_en_i) begin
      mode_d = cfg.dmr_enable ? DMR_RUN : NON_DMR;
    end

    // Splitting the pair is allowed at any time
    if ((mode_q == DMR_RUN) && !cfg.dmr_enable) begin
      mode_d = NON_DMR;
    end

    // Joining needs the cores to report they are in step
    if ((mode_q == NON_DMR) && cores_synch_i && cfg.dmr_enable) begin
      mode_d = DMR_RUN;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mode_q <= NON_DMR;
    end else begin
      mode_q <= mode_d;
    end
  end

  assign cfg.mode = mode_q;

  // Writebacks are only checked in lockstep
  assign compare_en_o = (mode_q == DMR_RUN);

  // Cores held while the shadow file is replayed
  assign recovery_req_o       = (mode_q == DMR_RESTORE);
  assign setback_o            = (mode_q == DMR_RESTORE);
  assign grp_in_independent_o = (mode_q == NON_DMR);

endmodule

/* dmr_compare.sv */
module dmr_compare (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             compare_en_i,
  // Writeback of core a
  input  logic                             a_wb_valid_i,
  input  logic [dmr_pkg::RegAddrWidth-1:0] a_wb_addr_i,
  input  logic [dmr_pkg::DataWidth-1:0]    a_wb_data_i,
  // Writeback of core b
  input  logic                             b_wb_valid_i,
  input  logic [dmr_pkg::RegAddrWidth-1:0] b_wb_addr_i,
  input  logic [dmr_pkg::DataWidth-1:0]    b_wb_data_i,
  // Registered result
  output logic                             error_o,
  output logic                             commit_valid_o,
  output logic [dmr_pkg::RegAddrWidth-1:0] commit_addr_o,
  output logic [dmr_pkg::DataWidth-1:0]    commit_data_o
);

  logic both_valid;
  logic same_payload;
  logic agree;
  logic mismatch;

  assign both_valid   = a_wb_valid_i && b_wb_valid_i;
  assign same_payload = (a_wb_addr_i == b_wb_addr_i) && (a_wb_data_i == b_wb_data_i);
  assign agree        = both_valid && same_payload;

  // One-sided valid also counts as a mismatch
  assign mismatch = (a_wb_valid_i != b_wb_valid_i) || (both_valid && !same_payload);

  // Strobes, only while the pair runs in lockstep
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      error_o        <= 1'b0;
      commit_valid_o <= 1'b0;
    end else begin
      error_o        <= compare_en_i && mismatch;
      commit_valid_o <= compare_en_i && agree;
    end
  end

  // Committed payload, core a taken as both agree
  always_ff @(posedge clk_i) begin
    if (agree) begin
      commit_addr_o <= a_wb_addr_i;
      commit_data_o <= a_wb_data_i;
    end
  end

endmodule

/* dmr_checkpoint.sv */
module dmr_checkpoint #(
  parameter int unsigned NumRegs = 8
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  // Agreed writebacks from the comparator
  input  logic                             commit_valid_i,
  input  logic [dmr_pkg::RegAddrWidth-1:0] commit_addr_i,
  input  logic [dmr_pkg::DataWidth-1:0]    commit_data_i,
  // Replay handshake with the FSM
  input  logic                             recovery_req_i,
  output logic                             recovery_done_o,
  // Replay stream towards the cores
  output logic                             restore_valid_o,
  output logic [dmr_pkg::RegAddrWidth-1:0] restore_addr_o,
  output logic [dmr_pkg::DataWidth-1:0]    restore_data_o
);
  import dmr_pkg::*;

  // Bits needed to select a shadow entry
  localparam int unsigned IdxWidth = (NumRegs > 1) ? $clog2(NumRegs) : 1;

  logic [DataWidth-1:0]    shadow_q [NumRegs];
  rec_state_e              state_q;
  logic [RegAddrWidth-1:0] idx_q;
  logic                    last_entry;
  logic                    commit_hit;

  // Entries beyond the shadow file are dropped
  assign commit_hit = commit_valid_i && (32'(commit_addr_i) < NumRegs);
  assign last_entry = (idx_q == RegAddrWidth'(NumRegs - 1));

  // Shadow register file
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NumRegs; i++) begin
        shadow_q[i] <= '0;
      end
    end else if (commit_hit) begin
      shadow_q[commit_addr_i[IdxWidth-1:0]] <= commit_data_i;
    end
  end

  // Replay engine, one entry per cycle from index 0
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= REC_IDLE;
      idx_q   <= '0;
    end else begin
      case (state_q)
        REC_IDLE: begin
          if (recovery_req_i) begin
            state_q <= REC_REPLAY;
            idx_q   <= '0;
          end
        end
        REC_REPLAY: begin
          if (last_entry) begin
            state_q <= REC_DONE;
          end else begin
            idx_q <= idx_q + RegAddrWidth'(1);
          end
        end
        // Done lasts a single cycle
        REC_DONE: state_q <= REC_IDLE;
        default:  state_q <= REC_IDLE;
      endcase
    end
  end

  assign restore_valid_o = (state_q == REC_REPLAY);
  assign restore_addr_o  = idx_q;
  assign restore_data_o  = shadow_q[idx_q[IdxWidth-1:0]];
  assign recovery_done_o = (state_q == REC_DONE);

endmodule

/* dmr_top.sv */
module dmr_top #(
  parameter int unsigned NumRegs       = 8,
  parameter bit          RapidRecovery = 1'b1
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  // Host register bus
  input  logic                             reg_req_i,
  input  logic                             reg_we_i,
  input  dmr_pkg::reg_addr_e               reg_addr_i,
  input  logic [dmr_pkg::DataWidth-1:0]    reg_wdata_i,
  output logic                             reg_ack_o,
  output logic [dmr_pkg::DataWidth-1:0]    reg_rdata_o,
  // Core pair state
  input  logic                             fetch_en_i,
  input  logic                             cores_synch_i,
  // Writebacks of both cores
  input  logic                             a_wb_valid_i,
  input  logic [dmr_pkg::RegAddrWidth-1:0] a_wb_addr_i,
  input  logic [dmr_pkg::DataWidth-1:0]    a_wb_data_i,
  input  logic                             b_wb_valid_i,
  input  logic [dmr_pkg::RegAddrWidth-1:0] b_wb_addr_i,
  input  logic [dmr_pkg::DataWidth-1:0]    b_wb_data_i,
  // Lockstep control towards the cores
  output logic                             setback_o,
  output logic                             sw_resynch_req_o,
  output logic                             grp_in_independent_o,
  // Shadow register replay
  output logic                             restore_valid_o,
  output logic [dmr_pkg::RegAddrWidth-1:0] restore_addr_o,
  output logic [dmr_pkg::DataWidth-1:0]    restore_data_o
);
  import dmr_pkg::*;

  logic                    compare_en;
  logic                    error;
  logic                    commit_valid;
  logic [RegAddrWidth-1:0] commit_addr;
  logic [DataWidth-1:0]    commit_data;
  logic                    recovery_req;
  logic                    recovery_done;

  // Config and status between register block and FSM
  dmr_cfg_if cfg ();

  dmr_regs #(
    .RapidRecovery(RapidRecovery)
  ) i_regs (
    .clk_i,
    .rst_ni,
    .reg_req_i,
    .reg_we_i,
    .reg_addr_i,
    .reg_wdata_i,
    .reg_ack_o,
    .reg_rdata_o,
    .cfg         (cfg.regs)
  );

  dmr_ctrl #(
    .RapidRecovery(RapidRecovery)
  ) i_ctrl (
    .clk_i,
    .rst_ni,
    .cfg                 (cfg.ctrl),
    .fetch_en_i,
    .cores_synch_i,
    .error_i             (error),
    .compare_en_o        (compare_en),
    .recovery_req_o      (recovery_req),
    .recovery_done_i     (recovery_done),
    .setback_o,
    .sw_resynch_req_o,
    .grp_in_independent_o
  );

  dmr_compare i_compare (
    .clk_i,
    .rst_ni,
    .compare_en_i  (compare_en),
    .a_wb_valid_i,
    .a_wb_addr_i,
    .a_wb_data_i,
    .b_wb_valid_i,
    .b_wb_addr_i,
    .b_wb_data_i,
    .error_o       (error),
    .commit_valid_o(commit_valid),
    .commit_addr_o (commit_addr),
    .commit_data_o (commit_data)
  );

  dmr_checkpoint #(
    .NumRegs(NumRegs)
  ) i_checkpoint (
    .clk_i,
    .rst_ni,
    .commit_valid_i (commit_valid),
    .commit_addr_i  (commit_addr),
    .commit_data_i  (commit_data),
    .recovery_req_i (recovery_req),
    .recovery_done_o(recovery_done),
    .restore_valid_o,
    .restore_addr_o,
    .restore_data_o
  );

endmodule

/* tb_dmr_top.sv */
module tb_dmr_top;
  timeunit 1ns;
  timeprecision 1ps;
  import dmr_pkg::*;

  localparam int unsigned NumRegs   = 8;
  localparam int unsigned NumPhases = 6;
  localparam int unsigned AckLimit  = 20;

  logic                    clk_i;
  logic                    rst_ni;
  logic                    reg_req_i;
  logic                    reg_we_i;
  reg_addr_e               reg_addr_i;
  logic [DataWidth-1:0]    reg_wdata_i;
  logic                    reg_ack_o;
  logic [DataWidth-1:0]    reg_rdata_o;
  logic                    fetch_en_i;
  logic                    cores_synch_i;
  logic                    a_wb_valid_i;
  logic [RegAddrWidth-1:0] a_wb_addr_i;
  logic [DataWidth-1:0]    a_wb_data_i;
  logic                    b_wb_valid_i;
  logic [RegAddrWidth-1:0] b_wb_addr_i;
  logic [DataWidth-1:0]    b_wb_data_i;
  logic                    setback_o;
  logic                    sw_resynch_req_o;
  logic                    grp_in_independent_o;
  logic                    restore_valid_o;
  logic [RegAddrWidth-1:0] restore_addr_o;
  logic [DataWidth-1:0]    restore_data_o;

  // Reference model of mode, shadow file and mismatch count
  dmr_mode_e               model_mode;
  logic [DataWidth-1:0]    model_shadow [NumRegs];
  int                      model_mismatch;
  logic [31:0]             lcg_state;

  // Scoreboard counters, filled by the monitor below
  int err_cnt     = 0;
  int check_cnt   = 0;
  int sw_pulses   = 0;
  int window_cnt  = 0;
  int last_window = 0;
  int sb_len      = 0;
  logic [RegAddrWidth-1:0] replay_addr [$];
  logic [DataWidth-1:0]    replay_data [$];

  dmr_top #(
    .NumRegs      (NumRegs),
    .RapidRecovery(1'b1)
  ) UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Run limit scaled to the number of test phases
  initial begin
    repeat (NumPhases * 400 + 16) @(posedge clk_i);
    $display("Timeout: the run did not finish within %0d cycles", NumPhases * 400 + 16);
    $display("Simulation failed");
    $finish;
  end

  // Pulse counts, replay stream and length of each setback window
  always @(posedge clk_i) begin
    if (sw_resynch_req_o) sw_pulses++;
    if (restore_valid_o) begin
      replay_addr.push_back(restore_addr_o);
      replay_data.push_back(restore_data_o);
    end
    if (setback_o) begin
      sb_len++;
    end else if (sb_len != 0) begin
      last_window = sb_len;
      sb_len      = 0;
      window_cnt++;
    end
  end

  // Four-phase ack rules
  assert property (@(posedge clk_i) disable iff (!rst_ni) $rose(reg_ack_o) |-> $past(reg_req_i))
    else begin
      err_cnt++;
      $display("[ERROR] %0t: ack rose without a request", $time);
    end
  assert property (@(posedge clk_i) disable iff (!rst_ni) $fell(reg_ack_o) |-> !$past(reg_req_i))
    else begin
      err_cnt++;
      $display("[ERROR] %0t: ack fell while req was high", $time);
    end
  assert property (@(posedge clk_i) disable iff (!rst_ni) (reg_req_i && reg_ack_o) |=> reg_ack_o)
    else begin
      err_cnt++;
      $display("[ERROR] %0t: ack dropped before req", $time);
    end

  // Replay only while the cores are held, addresses counting up
  assert property (@(posedge clk_i) disable iff (!rst_ni) restore_valid_o |-> setback_o)
    else begin
      err_cnt++;
      $display("[ERROR] %0t: restore outside setback", $time);
    end
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   (restore_valid_o && $past(restore_valid_o))
                   |-> (restore_addr_o == $past(restore_addr_o) + 1'b1))
    else begin
      err_cnt++;
      $display("[ERROR] %0t: restore address skipped", $time);
    end
  // Software resynch only from lockstep
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   sw_resynch_req_o |-> (!grp_in_independent_o && !setback_o))
    else begin
      err_cnt++;
      $display("[ERROR] %0t: resynch request outside DMR_RUN", $time);
    end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic check_eq(input string what, input logic [DataWidth-1:0] got,
                          input logic [DataWidth-1:0] exp);
    check_cnt++;
    assert (got === exp)
    else begin
      err_cnt++;
      $display("[ERROR] %0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    check_cnt++;
    assert (got === exp)
    else begin
      err_cnt++;
      $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk_i);
      #2;
    end
  endtask

  // One full handshake, entered and left 2 ns after an edge
  task automatic bus_access(input logic we, input reg_addr_e addr,
                            input logic [DataWidth-1:0] wdata,
                            output logic [DataWidth-1:0] rdata);
    int waited;
    reg_req_i   = 1'b1;
    reg_we_i    = we;
    reg_addr_i  = addr;
    reg_wdata_i = wdata;
    waited      = 0;
    do begin
      @(posedge clk_i);
      #2;
      waited++;
    end while (!reg_ack_o && waited < AckLimit);
    if (!reg_ack_o) begin
      err_cnt++;
      $display("Bus access to %s got no ack within %0d cycles", addr.name(), AckLimit);
    end
    check_eq("ack rise latency", waited, 1);
    rdata     = reg_rdata_o;
    reg_req_i = 1'b0;
    reg_we_i  = 1'b0;
    waited    = 0;
    do begin
      @(posedge clk_i);
      #2;
      waited++;
    end while (reg_ack_o && waited < AckLimit);
    if (reg_ack_o) begin
      err_cnt++;
      $display("Bus access to %s: ack stayed high after req dropped", addr.name());
    end
    check_eq("ack fall latency", waited, 1);
  endtask

  task automatic write_reg(input reg_addr_e addr, input logic [DataWidth-1:0] data);
    logic [DataWidth-1:0] ignored;
    bus_access(1'b1, addr, data, ignored);
  endtask

  task automatic read_reg(input reg_addr_e addr, output logic [DataWidth-1:0] data);
    bus_access(1'b0, addr, '0, data);
  endtask

  task automatic check_read(input string what, input reg_addr_e addr,
                            input logic [DataWidth-1:0] exp);
    logic [DataWidth-1:0] rdata;
    read_reg(addr, rdata);
    check_eq(what, rdata, exp);
  endtask

  task automatic pulse_synch();
    cores_synch_i = 1'b1;
    idle(1);
    cores_synch_i = 1'b0;
  endtask

  // Both cores write in the same cycle, core b flips data on disagree
  task automatic writeback(input logic [RegAddrWidth-1:0] addr,
                           input logic [DataWidth-1:0] data, input logic agree);
    a_wb_valid_i = 1'b1;
    b_wb_valid_i = 1'b1;
    a_wb_addr_i  = addr;
    b_wb_addr_i  = addr;
    a_wb_data_i  = data;
    b_wb_data_i  = agree ? data : ~data;
    if (agree && (model_mode == DMR_RUN) && (addr < NumRegs)) model_shadow[addr] = data;
    // Only a lockstep mismatch is counted
    if (!agree && (model_mode == DMR_RUN)) model_mismatch++;
    idle(1);
    a_wb_valid_i = 1'b0;
    b_wb_valid_i = 1'b0;
  endtask

  // Half the addresses land beyond the shadow file
  task automatic random_wb(input int n, input logic agree);
    logic [31:0] rnd;
    for (int i = 0; i < n; i++) begin
      rnd = lcg_next();
      writeback(RegAddrWidth'(rnd[3:0]), lcg_next(), agree);
    end
  endtask

  task automatic expect_replay(input string label, input int windows_before);
    int         waited;
    rec_state_e done_state;
    waited     = 0;
    done_state = REC_DONE;
    while (window_cnt == windows_before && waited < 4 * NumRegs) begin
      idle(1);
      waited++;
    end
    if (window_cnt == windows_before) begin
      err_cnt++;
      $display("%s: setback never ended, replay did not reach %s", label, done_state.name());
    end else begin
      check_eq({label, " setback length"}, last_window, NumRegs + 2);
      check_eq({label, " replay count"}, replay_addr.size(), NumRegs);
      for (int i = 0; i < replay_addr.size() && i < NumRegs; i++) begin
        check_eq({label, " replay address"}, DataWidth'(replay_addr[i]), i);
        check_eq({label, " replay data"}, replay_data[i], model_shadow[i]);
      end
    end
    replay_addr.delete();
    replay_data.delete();
  endtask

  initial begin
    int base_sw;
    int base_win;
    rst_ni         = 1'b0;
    reg_req_i      = 1'b0;
    reg_we_i       = 1'b0;
    reg_addr_i     = REG_CTRL;
    reg_wdata_i    = '0;
    fetch_en_i     = 1'b0;
    cores_synch_i  = 1'b0;
    a_wb_valid_i   = 1'b0;
    a_wb_addr_i    = '0;
    a_wb_data_i    = '0;
    b_wb_valid_i   = 1'b0;
    b_wb_addr_i    = '0;
    b_wb_data_i    = '0;
    lcg_state      = 32'd72676;
    model_mode     = NON_DMR;
    model_mismatch = 0;
    for (int i = 0; i < NumRegs; i++) model_shadow[i] = '0;
    repeat (16) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    // Register bus and reset state
    check_bit("setback_o after reset", setback_o, 1'b0);
    check_bit("restore_valid_o after reset", restore_valid_o, 1'b0);
    check_bit("grp_in_independent_o after reset", grp_in_independent_o, 1'b1);
    check_read("STATUS after reset", REG_STATUS, DataWidth'(NON_DMR));
    check_read("CTRL after reset", REG_CTRL, 32'h0);
    write_reg(REG_CTRL, 32'h2);
    check_read("CTRL rapid bit", REG_CTRL, 32'h2);
    write_reg(REG_CTRL, 32'h4);
    check_read("CTRL force bit", REG_CTRL, 32'h4);
    write_reg(REG_CTRL, 32'h1);
    check_read("CTRL enable bit", REG_CTRL, 32'h1);
    write_reg(REG_CTRL, 32'h0);

    // Mode switching
    write_reg(REG_CTRL, 32'h1);
    model_mode = DMR_RUN;
    check_read("STATUS enabled before fetch", REG_STATUS, DataWidth'(DMR_RUN));
    check_bit("grp_in_independent_o in DMR_RUN", grp_in_independent_o, 1'b0);
    fetch_en_i = 1'b1;
    write_reg(REG_CTRL, 32'h0);
    model_mode = NON_DMR;
    check_read("STATUS after split", REG_STATUS, DataWidth'(NON_DMR));
    check_bit("grp_in_independent_o after split", grp_in_independent_o, 1'b1);
    write_reg(REG_CTRL, 32'h1);
    idle(3);
    check_read("STATUS before synch", REG_STATUS, DataWidth'(NON_DMR));
    pulse_synch();
    model_mode = DMR_RUN;
    check_read("STATUS after synch", REG_STATUS, DataWidth'(DMR_RUN));

    // Software path, rapid recovery still clear
    random_wb(8, 1'b1);
    base_sw = sw_pulses;
    random_wb(1, 1'b0);
    idle(4);
    check_eq("sw_resynch_req_o pulses", sw_pulses - base_sw, 1);
    check_eq("restores on software path", replay_addr.size(), 0);
    check_read("STATUS after software path", REG_STATUS, DataWidth'(DMR_RUN));
    check_read("MISMATCH after software path", REG_MISMATCH, 32'(model_mismatch));

    // Rapid recovery on a mismatch
    write_reg(REG_CTRL, 32'h3);
    random_wb(32, 1'b1);
    base_win = window_cnt;
    random_wb(1, 1'b0);
    expect_replay("mismatch recovery", base_win);
    check_read("STATUS after recovery", REG_STATUS, DataWidth'(DMR_RUN));
    check_read("MISMATCH after recovery", REG_MISMATCH, 32'(model_mismatch));

    // Forced recovery leaves the count alone
    random_wb(16, 1'b1);
    base_win = window_cnt;
    write_reg(REG_CTRL, 32'h7);
    expect_replay("forced recovery", base_win);
    check_read("CTRL after forced recovery", REG_CTRL, 32'h3);
    check_read("MISMATCH after forced recovery", REG_MISMATCH, 32'(model_mismatch));
    check_read("STATUS after forced recovery", REG_STATUS, DataWidth'(DMR_RUN));

    // Independent mode, nothing compared and nothing stored
    write_reg(REG_CTRL, 32'h2);
    model_mode = NON_DMR;
    check_bit("grp_in_independent_o when split", grp_in_independent_o, 1'b1);
    base_sw = sw_pulses;
    random_wb(6, 1'b0);
    random_wb(12, 1'b1);
    idle(4);
    check_eq("sw_resynch_req_o in NON_DMR", sw_pulses - base_sw, 0);
    check_read("MISMATCH in NON_DMR", REG_MISMATCH, 32'(model_mismatch));
    check_read("STATUS in NON_DMR", REG_STATUS, DataWidth'(NON_DMR));
    write_reg(REG_CTRL, 32'h3);
    pulse_synch();
    model_mode = DMR_RUN;
    base_win = window_cnt;
    write_reg(REG_CTRL, 32'h7);
    expect_replay("replay after independent phase", base_win);

    // Any write clears a nonzero mismatch count
    write_reg(REG_MISMATCH, 32'h5);
    model_mismatch = 0;
    check_read("MISMATCH after clear", REG_MISMATCH, 32'(model_mismatch));

    $display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* project.f */
dmr_pkg.sv
dmr_cfg_if.sv
dmr_regs.sv
dmr_ctrl.sv
dmr_compare.sv
dmr_checkpoint.sv
dmr_top.sv
tb_dmr_top.sv

/* Makefile */
TOP := tb_dmr_top

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f project.f --top-module dmr_top
	verilator --lint-only --timing -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) \
		-Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "^Simulation passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
